// File: src/aln_pkg.sv
// shared widths, slot names and bus structs for the instruction aligner and its bench
package aln_pkg;

   localparam int NUM_FB       = 3;    // fetch buffers in the queue
   localparam int HW_PER_FETCH = 2;    // halfwords per fetch word
   localparam int PC_W         = 31;   // halfword pc, bits 31:1
   localparam int ICAF_TYPE_W  = 2;

   // queue slot, used for read and write pointers
   typedef enum logic [1:0] {
      SLOT0 = 2'd0,
      SLOT1 = 2'd1,
      SLOT2 = 2'd2
   } fb_slot_e;

   // ******************************
   // buses
   // ******************************

   typedef struct packed {
      logic [HW_PER_FETCH-1:0] val;          // right justified
      logic [31:0]             data;         // memory order
      logic [PC_W-1:0]         pc;           // pc of the low halfword
      logic [HW_PER_FETCH-1:0] icaf;
      logic [ICAF_TYPE_W-1:0]  icaf_type;    // one type per fetch
      logic [HW_PER_FETCH-1:0] dbecc;
   } fetch_word_t;

   // one buffer after the offset is applied, low half is next to go
   typedef struct packed {
      logic [31:0]             data;
      logic [PC_W-1:0]         pc;
      logic [HW_PER_FETCH-1:0] icaf;
      logic [HW_PER_FETCH-1:0] dbecc;
      logic [ICAF_TYPE_W-1:0]  icaf_type;
   } fb_view_t;

   typedef struct packed {
      logic                   valid;
      logic [31:0]            instr;         // 2B inst has upper half zero
      logic [PC_W-1:0]        pc;
      logic                   pc4;           // 4 byte instruction
      logic [15:0]            cinst;
      logic                   icaf;
      logic [ICAF_TYPE_W-1:0] icaf_type;
      logic                   icaf_second;   // only upper half faulted
      logic                   dbecc;
   } i0_pkt_t;

   // advance a slot pointer, wraps at NUM_FB
   function automatic fb_slot_e slot_add(fb_slot_e slot, logic [1:0] step);
      logic [2:0] sum;
      sum = {1'b0, slot} + {1'b0, step};
      if (sum >= 3'(NUM_FB)) begin
         sum = sum - 3'(NUM_FB);
      end
      return fb_slot_e'(sum[1:0]);
   endfunction

endpackage

// File: src/fetch_buf_queue.sv
// three-slot fetch buffer store, presents the two oldest slots to the aligner as offset views
`timescale 1ns/100ps

module fetch_buf_queue
   import aln_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  fetch_word_t fetch,          // word from fetch
   input  logic        wr_en,          // write fetch into slot at wrptr
   input  logic        consume1,       // oldest slot drained
   input  logic        consume2,       // oldest two slots drained
   input  logic        flush,
   input  logic        f0_shift_2b,    // low half of f0 taken
   input  logic        f1_shift_2b,    // low half of f1 taken
   output fb_view_t    f0_view,
   output fb_view_t    f1_view
);

   fb_view_t          slot_q [NUM_FB];   // buffered fetch words
   fb_view_t          wr_entry;
   fb_slot_e          wrptr_q, wrptr_d;
   fb_slot_e          rdptr_q, rdptr_d;
   fb_slot_e          rd_next;           // slot holding f1
   logic [NUM_FB-1:0] slot_wen;
   logic [NUM_FB-1:0] off_q, off_d;      // lower half used in each slot
   logic [1:0]        fill_q, fill_d;    // slots holding data

   // drop the used low half by moving data down and pc one halfword up
   function automatic fb_view_t apply_off(fb_view_t raw, logic off);
      fb_view_t v;
      v = raw;
      if (off) begin
         v.data  = {16'h0000, raw.data[31:16]};
         v.pc    = raw.pc + 1'b1;
         v.icaf  = {1'b0, raw.icaf[1]};
         v.dbecc = {1'b0, raw.dbecc[1]};
      end
      return v;
   endfunction

   // ******************************
   // write side
   // ******************************

   always_comb begin
      wr_entry.data      = fetch.data;
      wr_entry.pc        = fetch.pc;
      wr_entry.icaf      = fetch.icaf;
      wr_entry.dbecc     = fetch.dbecc;
      wr_entry.icaf_type = fetch.icaf_type;
   end

   always_comb begin
      for (int i = 0; i < NUM_FB; i++) begin
         slot_wen[i] = wr_en & (wrptr_q == 2'(i));
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_FB; i++) begin
         if (slot_wen[i]) begin
            slot_q[i] <= wr_entry;
         end
      end
   end

   // ******************************
   // pointers and offsets
   // ******************************

   assign rd_next = slot_add(rdptr_q, 2'd1);

   always_comb begin
      wrptr_d = wr_en ? slot_add(wrptr_q, 2'd1) : wrptr_q;
      rdptr_d = rdptr_q;
      fill_d  = fill_q + {1'b0, wr_en};
      if (consume2) begin
         rdptr_d = slot_add(rdptr_q, 2'd2);
         fill_d  = fill_d - 2'd2;
      end else if (consume1) begin
         rdptr_d = rd_next;
         fill_d  = fill_d - 2'd1;
      end
      if (flush) begin                 // everything goes back to empty
         wrptr_d = SLOT0;
         rdptr_d = SLOT0;
         fill_d  = '0;
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_FB; i++) begin
         if (flush || slot_wen[i]) begin
            off_d[i] = 1'b0;                          // new word starts at low half
         end else if (rdptr_q == 2'(i)) begin
            off_d[i] = off_q[i] | f0_shift_2b;
         end else if (rd_next == 2'(i)) begin
            off_d[i] = off_q[i] | f1_shift_2b;
         end else begin
            off_d[i] = off_q[i];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wrptr_q <= SLOT0;
         rdptr_q <= SLOT0;
         off_q   <= '0;
         fill_q  <= '0;
      end else begin
         wrptr_q <= wrptr_d;
         rdptr_q <= rdptr_d;
         off_q   <= off_d;
         fill_q  <= fill_d;
      end
   end

   // oldest two slots rotated and offset
   assign f0_view = apply_off(slot_q[rdptr_q], off_q[rdptr_q]);
   assign f1_view = apply_off(slot_q[rd_next], off_q[rd_next]);

   // fetch control counts buffers itself and must hold off at three
   a_no_wr_full: assert property (@(posedge clk) disable iff (!arst_n)
      (fill_q == 2'(NUM_FB)) |-> !wr_en);

   // buffer control only drains slots that actually hold a word
   a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
      (consume1 | consume2) |-> (fill_q >= (consume2 ? 2'd2 : 2'd1)));

endmodule

// File: src/fetch_buf_ctl.sv
// halfword valid tracking for f0/f1/f2, shift and placement decisions, error stall and consume strobes
`timescale 1ns/100ps

module fetch_buf_ctl
   import aln_pkg::*;
(
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic [HW_PER_FETCH-1:0] fetch_val,          // right justified
   input  logic                    decode,             // decode takes the inst this cycle
   input  logic                    flush,
   input  logic                    async_error_start,  // ecc/parity error pulse
   input  logic                    first4b,            // head inst is 4 bytes
   output logic [HW_PER_FETCH-1:0] f0val,
   output logic [HW_PER_FETCH-1:0] f1val,
   output logic                    wr_en,
   output logic                    consume1,
   output logic                    consume2,
   output logic                    f0_shift_2b,
   output logic                    f1_shift_2b,
   output logic                    instr_aligned
);

   logic [HW_PER_FETCH-1:0] f2val;
   logic [HW_PER_FETCH-1:0] f0val_d, f1val_d, f2val_d;
   logic [HW_PER_FETCH-1:0] sf0val, sf1val;   // after this cycle's shift
   logic                    error_stall, error_stall_d;
   logic                    ifvalid;
   logic                    inst_ok;
   logic                    i0_shift, shift_2b, shift_4b;
   logic                    consume_fb0, consume_fb1;
   logic                    shift_f1_f0, shift_f2_f0, shift_f2_f1;
   logic                    fetch_to_f0, fetch_to_f1, fetch_to_f2;

   // ******************************
   // shift out of f0/f1
   // ******************************

   // halfwords the head inst needs are there
   assign inst_ok  = first4b ? (f0val[1] | (f0val[0] & f1val[0])) : f0val[0];

   assign i0_shift = decode & inst_ok & ~error_stall;
   assign shift_2b = i0_shift & ~first4b;
   assign shift_4b = i0_shift &  first4b;

   assign f0_shift_2b = (shift_2b & f0val[0]) |
                        (shift_4b & f0val[0] & ~f0val[1]);
   assign f1_shift_2b =  shift_4b & f0val[0] & ~f0val[1];   // 4B straddles f0/f1

   assign sf0val = shift_2b ? {1'b0, f0val[1]} :
                   shift_4b ? 2'b00 : f0val;
   assign sf1val = f1_shift_2b ? {1'b0, f1val[1]} : f1val;

   assign consume_fb0   = ~sf0val[0] & f0val[0];
   assign consume_fb1   = ~sf1val[0] & f1val[0];
   assign consume1      = consume_fb0 & ~consume_fb1 & ~flush;
   assign consume2      = consume_fb0 &  consume_fb1 & ~flush;
   assign instr_aligned = i0_shift & ~flush;

   // ******************************
   // placement of the fetch
   // ******************************

   assign ifvalid = fetch_val[0];
   assign wr_en   = ifvalid & ~flush;

   // stages move down into empty ones, fetch lands in the lowest free stage
   assign shift_f1_f0 = ~sf0val[0] &  sf1val[0];
   assign shift_f2_f0 = ~sf0val[0] & ~sf1val[0] &  f2val[0];
   assign shift_f2_f1 = ~sf0val[0] &  sf1val[0] &  f2val[0];

   assign fetch_to_f0 = ifvalid & ~sf0val[0] & ~sf1val[0] & ~f2val[0];
   assign fetch_to_f1 = ifvalid & ((~sf0val[0] & ~sf1val[0] &  f2val[0]) |
                                   (~sf0val[0] &  sf1val[0] & ~f2val[0]) |
                                   ( sf0val[0] & ~sf1val[0] & ~f2val[0]));
   assign fetch_to_f2 = ifvalid & ((~sf0val[0] &  sf1val[0] &  f2val[0]) |
                                   ( sf0val[0] &  sf1val[0] & ~f2val[0]));

   assign f2val_d = flush       ? 2'b00     :
                    fetch_to_f2 ? fetch_val :
                    (shift_f2_f1 | shift_f2_f0) ? 2'b00 : f2val;

   assign f1val_d = flush       ? 2'b00     :
                    fetch_to_f1 ? fetch_val :
                    shift_f2_f1 ? f2val     :
                    shift_f1_f0 ? 2'b00     : sf1val;

   assign f0val_d = flush       ? 2'b00     :
                    fetch_to_f0 ? fetch_val :
                    shift_f2_f0 ? f2val     :
                    shift_f1_f0 ? sf1val    : sf0val;

   // held until the pipe flushes
   assign error_stall_d = (error_stall | async_error_start) & ~flush;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         f0val       <= '0;
         f1val       <= '0;
         f2val       <= '0;
         error_stall <= 1'b0;
      end else begin
         f0val       <= f0val_d;
         f1val       <= f1val_d;
         f2val       <= f2val_d;
         error_stall <= error_stall_d;
      end
   end

   a_f2_needs_f1: assert property (@(posedge clk) disable iff (!arst_n)
      f2val[0] |-> f1val[0]);

endmodule

// File: src/inst_aligner.sv
// cuts the head instruction out of the f0/f1 views and derives its length, valid and fault flags
`timescale 1ns/100ps

module inst_aligner
   import aln_pkg::*;
(
   input  fb_view_t                f0_view,
   input  fb_view_t                f1_view,
   input  logic [HW_PER_FETCH-1:0] f0val,
   input  logic [HW_PER_FETCH-1:0] f1val,
   output i0_pkt_t                 i0,
   output logic                    first4b
);

   logic                    f0_one;       // one halfword left in f0
   logic [31:0]             aligndata;
   logic [HW_PER_FETCH-1:0] alignval;
   logic [HW_PER_FETCH-1:0] alignicaf;
   logic [HW_PER_FETCH-1:0] aligndbecc;
   logic [HW_PER_FETCH-1:0] icaf_eff;

   assign f0_one = f0val[0] & ~f0val[1];

   // ******************************
   // align
   // ******************************

   // straddle case: f1 low half sits on top of f0 low half
   assign aligndata  = f0_one ? {f1_view.data[15:0], f0_view.data[15:0]} : f0_view.data;

   assign alignval   = f0val[1] ? 2'b11 :
                       f0val[0] ? {f1val[0], 1'b1} : 2'b00;

   assign alignicaf  = f0_one ? {f1_view.icaf[0], f0_view.icaf[0]} : f0_view.icaf;
   assign aligndbecc = f0_one ? {f1_view.dbecc[0], f0_view.dbecc[0]} : f0_view.dbecc;

   assign first4b    = (aligndata[1:0] == 2'b11);

   // either error kind on the low half counts as a first half fault
   assign icaf_eff   = alignicaf | aligndbecc;

   // ******************************
   // packet to decode
   // ******************************

   always_comb begin
      i0.valid       = first4b ? alignval[1] : alignval[0];
      i0.instr       = '0;
      if (i0.valid) begin
         i0.instr = first4b ? aligndata : {16'h0000, aligndata[15:0]};   // decoder expands 2B
      end
      i0.pc          = f0_view.pc;
      i0.pc4         = first4b;
      i0.cinst       = aligndata[15:0];
      i0.icaf        = first4b ? (|alignicaf) : alignicaf[0];
      i0.dbecc       = first4b ? (|aligndbecc) : aligndbecc[0];
      i0.icaf_second = first4b & ~icaf_eff[0] & icaf_eff[1];
      // type belongs to the fetch that faulted
      i0.icaf_type   = (i0.icaf_second & f0_one) ? f1_view.icaf_type : f0_view.icaf_type;
   end

endmodule

// File: src/ifu_aln_ctl.sv
// aligner top level, connects the buffer queue, buffer control and instruction aligner
`timescale 1ns/100ps

module ifu_aln_ctl
   import aln_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  fetch_word_t fetch,
   input  logic        decode,
   input  logic        flush,
   input  logic        async_error_start,
   output i0_pkt_t     i0,
   output logic        consume1,            // to fetch control buffer count
   output logic        consume2,
   output logic        instr_aligned
);

   fb_view_t                f0_view, f1_view;
   logic [HW_PER_FETCH-1:0] f0val, f1val;
   logic                    first4b;
   logic                    wr_en;
   logic                    f0_shift_2b, f1_shift_2b;

   fetch_buf_queue u_queue (
      .clk         (clk),
      .arst_n      (arst_n),
      .fetch       (fetch),
      .wr_en       (wr_en),
      .consume1    (consume1),
      .consume2    (consume2),
      .flush       (flush),
      .f0_shift_2b (f0_shift_2b),
      .f1_shift_2b (f1_shift_2b),
      .f0_view     (f0_view),
      .f1_view     (f1_view)
   );

   fetch_buf_ctl u_ctl (
      .clk               (clk),
      .arst_n            (arst_n),
      .fetch_val         (fetch.val),
      .decode            (decode),
      .flush             (flush),
      .async_error_start (async_error_start),
      .first4b           (first4b),
      .f0val             (f0val),
      .f1val             (f1val),
      .wr_en             (wr_en),
      .consume1          (consume1),
      .consume2          (consume2),
      .f0_shift_2b       (f0_shift_2b),
      .f1_shift_2b       (f1_shift_2b),
      .instr_aligned     (instr_aligned)
   );

   inst_aligner u_align (
      .f0_view (f0_view),
      .f1_view (f1_view),
      .f0val   (f0val),
      .f1val   (f1val),
      .i0      (i0),
      .first4b (first4b)
   );

endmodule

// File: bench/clk_gen.sv
// clock and reset source for the aligner bench, 10 ns period with reset held for two cycles
`timescale 1ns/100ps

module clk_gen (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial begin
      arst_n = 1'b0;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule

// File: bench/tb_aln.sv
// testbench for the aligner top level, applies a row table and checks against a halfword model
`timescale 1ns/100ps

module tb_aln
   import aln_pkg::*;
();

   typedef struct packed {
      fetch_word_t fw;
      logic        decode;
      logic        flush;
      logic        aes;                  // async error pulse
   } row_t;

   typedef struct packed {
      logic [15:0]            data;
      logic [PC_W-1:0]        pc;
      logic                   icaf;
      logic                   dbecc;
      logic [ICAF_TYPE_W-1:0] icaf_type;
      logic                   last;      // last halfword of its fetch word
   } hw_t;

   logic        clk, arst_n;
   fetch_word_t fetch;
   logic        decode, flush, async_error_start;
   i0_pkt_t     i0;
   logic        consume1, consume2, instr_aligned;

   row_t        rows[$];                 // stimulus table of the running test
   hw_t         model_q[$];              // halfwords held by the DUT
   logic [31:0] lcg_state;
   int          errors, n_pass, n_fail;
   int          buf_cnt;                 // words held, counted like fetch control
   int          hw_fetched, hw_taken;
   logic        stalled, timed_out;
   logic        hold_head;               // head may not move this cycle
   logic        after_flush;
   i0_pkt_t     last_i0;

   clk_gen u_clk (
      .clk    (clk),
      .arst_n (arst_n)
   );

   ifu_aln_ctl DUT (
      .clk               (clk),
      .arst_n            (arst_n),
      .fetch             (fetch),
      .decode            (decode),
      .flush             (flush),
      .async_error_start (async_error_start),
      .i0                (i0),
      .consume1          (consume1),
      .consume2          (consume2),
      .instr_aligned     (instr_aligned)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic row_t make_row(logic [1:0] val, logic [PC_W-1:0] pc, logic [31:0] data,
                                     logic dec);
      row_t r;
      r         = '0;
      r.fw.val  = val;
      r.fw.pc   = pc;
      r.fw.data = data;
      r.decode  = dec;
      return r;
   endfunction

   function automatic hw_t make_hw(row_t r, int idx);
      hw_t h;
      h.data      = (idx == 0) ? r.fw.data[15:0] : r.fw.data[31:16];
      h.pc        = r.fw.pc + PC_W'(idx);
      h.icaf      = r.fw.icaf[idx];
      h.dbecc     = r.fw.dbecc[idx];
      h.icaf_type = r.fw.icaf_type;
      h.last      = (idx == 1) || !r.fw.val[1];
      return h;
   endfunction

   task automatic add_fetch(logic [1:0] val, logic [PC_W-1:0] pc, logic [31:0] data, logic dec);
      rows.push_back(make_row(val, pc, data, dec));
   endtask

   task automatic add_ctl(logic dec, logic fl, logic aes);
      row_t r;
      r       = make_row(2'b00, '0, 32'h0, dec);
      r.flush = fl;
      r.aes   = aes;
      rows.push_back(r);
   endtask

   task automatic add_fault(logic [PC_W-1:0] pc, logic [31:0] data, logic [1:0] icaf,
                            logic [1:0] dbecc, logic [1:0] typ);
      row_t r;
      r              = make_row(2'b11, pc, data, 1'b1);
      r.fw.icaf      = icaf;
      r.fw.dbecc     = dbecc;
      r.fw.icaf_type = typ;
      rows.push_back(r);
   endtask

   task automatic fail_value(string sig, logic [63:0] exp, logic [63:0] got);
      $display("[FAIL] t=%0t %s exp=%0h got=%0h", $time, sig, exp, got);
      errors++;
   endtask

   task automatic fail_note(string what);
      $display("t=%0t: %s", $time, what);
      errors++;
   endtask

   // ******************************
   // one cycle against the model
   // ******************************

   task automatic step_cycle(row_t r);
      hw_t         h0, h1;
      logic        exp_valid, is4, taken, exp_second;
      logic [31:0] exp_instr;
      int          n_last;
      @(posedge clk);
      fetch             <= r.fw;
      decode            <= r.decode;
      flush             <= r.flush;
      async_error_start <= r.aes;
      @(negedge clk);                    // outputs settled mid-cycle
      h0        = '0;
      h1        = '0;
      exp_valid = 1'b0;
      is4       = 1'b0;
      if (model_q.size() > 0) begin
         h0        = model_q[0];
         is4       = (h0.data[1:0] == 2'b11);
         exp_valid = !is4 || (model_q.size() > 1);
      end
      if (is4 && exp_valid)
         h1 = model_q[1];
      taken      = exp_valid & r.decode & ~stalled & ~r.flush;
      exp_instr  = is4 ? {h1.data, h0.data} : {16'h0000, h0.data};
      exp_second = is4 & ~(h0.icaf | h0.dbecc) & (h1.icaf | h1.dbecc);
      n_last     = taken ? (int'(h0.last) + int'(is4 & h1.last)) : 0;

      if (i0.valid !== exp_valid)
         fail_value("i0.valid", exp_valid, i0.valid);
      if (exp_valid && i0.valid) begin
         if (i0.instr !== exp_instr)
            fail_value("i0.instr", exp_instr, i0.instr);
         if (i0.pc !== h0.pc)
            fail_value("i0.pc", h0.pc, i0.pc);
         if (i0.pc4 !== is4)
            fail_value("i0.pc4", is4, i0.pc4);
         if (i0.cinst !== h0.data)
            fail_value("i0.cinst", h0.data, i0.cinst);
         if (i0.icaf !== (h0.icaf | (is4 & h1.icaf)))
            fail_value("i0.icaf", h0.icaf | (is4 & h1.icaf), i0.icaf);
         if (i0.dbecc !== (h0.dbecc | (is4 & h1.dbecc)))
            fail_value("i0.dbecc", h0.dbecc | (is4 & h1.dbecc), i0.dbecc);
         if (i0.icaf_second !== exp_second)
            fail_value("i0.icaf_second", exp_second, i0.icaf_second);
         if (i0.icaf_type !== (exp_second ? h1.icaf_type : h0.icaf_type))
            fail_value("i0.icaf_type", exp_second ? h1.icaf_type : h0.icaf_type, i0.icaf_type);
      end
      if (instr_aligned !== taken)
         fail_value("instr_aligned", taken, instr_aligned);
      if (consume1 !== (n_last == 1))
         fail_value("consume1", n_last == 1, consume1);
      if (consume2 !== (n_last == 2))
         fail_value("consume2", n_last == 2, consume2);
      if (hold_head && (i0.pc !== last_i0.pc || i0.instr !== last_i0.instr))
         fail_note("head instruction moved although it was not taken");
      if (after_flush && i0.valid)
         fail_note("instruction still valid in the cycle after a flush");

      // move the model past the coming edge
      if (instr_aligned)
         hw_taken += i0.pc4 ? 2 : 1;
      if (taken) begin
         h0 = model_q.pop_front();
         if (is4)
            h1 = model_q.pop_front();
      end
      if (r.flush) begin
         model_q.delete();
         buf_cnt = 0;
      end else begin
         buf_cnt += int'(r.fw.val[0]) - int'(consume1) - 2 * int'(consume2);
         for (int i = 0; i < HW_PER_FETCH; i++) begin
            if (r.fw.val[i]) begin
               model_q.push_back(make_hw(r, i));
               hw_fetched++;
            end
         end
      end
      stalled     = (stalled | r.aes) & ~r.flush;
      hold_head   = exp_valid & ~taken & ~r.flush;
      after_flush = r.flush;
      last_i0     = i0;
   endtask

   task automatic apply_rows();
      row_t r;
      int   idx;
      int   held;
      idx  = 0;
      held = 0;
      while (idx < rows.size() && !timed_out) begin
         r = rows[idx];
         if (r.fw.val[0] && !r.flush && buf_cnt >= NUM_FB) begin
            r.fw.val = 2'b00;            // three words held, fetch waits
            r.decode = 1'b1;
            r.aes    = 1'b0;
            held++;
            if (held > 20) begin
               $display("timeout: buffers stayed full for %0d cycles", held);
               timed_out = 1'b1;
            end
         end else begin
            held = 0;
            idx++;
         end
         if (!timed_out)
            step_cycle(r);
      end
      rows.delete();
   endtask

   task automatic drain();
      int n;
      n = 0;
      while ((model_q.size() > 0 || i0.valid) && !timed_out) begin
         step_cycle(make_row(2'b00, '0, 32'h0, 1'b1));
         n++;
         if (n > 40) begin
            $display("timeout: instruction stream did not drain in %0d cycles", n);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic finish_test(string name, int err_start);
      if (errors == err_start && !timed_out) begin
         n_pass++;
         $display("test %s: passed", name);
      end else begin
         n_fail++;
         $display("test %s: failed with %0d errors", name, errors - err_start);
      end
   endtask

   // ******************************
   // tests
   // ******************************

   task automatic test_mixed();
      int              e0;
      logic [31:0]     r;
      logic [15:0]     hws[$];
      logic [PC_W-1:0] pc;
      e0         = errors;
      hw_fetched = 0;
      hw_taken   = 0;
      for (int i = 0; i < 40; i++) begin
         r = lcg_next();
         if (r[28]) begin
            hws.push_back({r[15:2], 2'b11});                  // 4B, may straddle
            hws.push_back(r[31:16]);
         end else begin
            hws.push_back({r[15:2], (r[17:16] == 2'b11) ? 2'b01 : r[17:16]});
         end
      end
      if (hws.size() % 2 != 0)
         hws.push_back(16'h0001);                             // pad the last word with a 2B
      pc = 31'h0000_0800;
      for (int i = 0; i < hws.size(); i += 2) begin
         r = lcg_next();
         add_fetch(2'b11, pc, {hws[i+1], hws[i]}, r[27] | r[22]);
         pc = pc + 31'd2;
      end
      apply_rows();
      drain();
      if (hw_taken != hw_fetched)
         fail_note($sformatf("%0d halfwords taken but %0d fetched", hw_taken, hw_fetched));
      if (buf_cnt != 0)
         fail_note($sformatf("buffer count is %0d after the stream drained", buf_cnt));
      finish_test("mixed_stream", e0);
   endtask

   task automatic test_partial();
      int e0;
      e0 = errors;
      add_fetch(2'b01, 31'h0000_1000, 32'hffff_0004, 1'b1);   // upper half not valid
      add_fetch(2'b11, 31'h0012_3450, {16'h0009, 16'h0008}, 1'b1);
      apply_rows();
      drain();
      finish_test("partial_fetch", e0);
   endtask

   task automatic test_faults();
      int e0;
      e0 = errors;
      add_fault(31'h4000, {16'h1234, 16'h5673}, 2'b10, 2'b00, 2'd1);
      add_fault(31'h4002, {16'h0003, 16'h0005}, 2'b00, 2'b00, 2'd1);
      add_fault(31'h4004, {16'h000a, 16'hbeef}, 2'b01, 2'b00, 2'd2);   // straddle, upper bad
      add_fault(31'h4006, {16'h0007, 16'h0010}, 2'b10, 2'b01, 2'd3);
      add_fault(31'h4008, {16'h0004, 16'hcafe}, 2'b01, 2'b00, 2'd2);   // both halves bad
      add_fault(31'h400a, {16'h8765, 16'h4323}, 2'b00, 2'b10, 2'd0);
      apply_rows();
      drain();
      finish_test("faults", e0);
   endtask

   task automatic test_hold();
      int e0;
      e0 = errors;
      add_fetch(2'b11, 31'h5000, {16'h0022, 16'h0033}, 1'b0);
      add_fetch(2'b11, 31'h5002, {16'h0011, 16'h0044}, 1'b0);
      repeat (4) add_ctl(1'b0, 1'b0, 1'b0);
      apply_rows();
      drain();
      finish_test("decode_hold", e0);
   endtask

   task automatic test_flush();
      int   e0;
      row_t r;
      e0 = errors;
      add_fetch(2'b11, 31'h6000, {16'h0101, 16'h0202}, 1'b0);
      add_fetch(2'b11, 31'h6002, {16'h0404, 16'h0303}, 1'b0);
      r       = make_row(2'b11, 31'h6004, {16'h0505, 16'h0606}, 1'b1);
      r.flush = 1'b1;                                         // fetch in the flush cycle is lost
      rows.push_back(r);
      add_ctl(1'b0, 1'b0, 1'b0);
      add_fetch(2'b11, 31'h7000, {16'h0006, 16'h0005}, 1'b0);
      add_ctl(1'b0, 1'b0, 1'b0);
      apply_rows();
      drain();
      finish_test("flush", e0);
   endtask

   task automatic test_stall();
      int e0;
      e0 = errors;
      add_fetch(2'b11, 31'h8000, {16'h0021, 16'h0011}, 1'b1);
      add_fetch(2'b11, 31'h8002, {16'h0041, 16'h0031}, 1'b1);
      add_ctl(1'b1, 1'b0, 1'b1);
      repeat (3) add_ctl(1'b1, 1'b0, 1'b0);                   // stalled with decode high
      add_fetch(2'b11, 31'h8004, {16'h0061, 16'h0051}, 1'b1);
      add_ctl(1'b1, 1'b1, 1'b0);
      add_fetch(2'b11, 31'h9000, {16'h0002, 16'h0001}, 1'b1);
      apply_rows();
      drain();
      finish_test("error_stall", e0);
   endtask

   initial begin
      int n;
      fetch             = '0;
      decode            = 1'b0;
      flush             = 1'b0;
      async_error_start = 1'b0;
      lcg_state         = 32'hfceb;
      errors            = 0;
      n_pass            = 0;
      n_fail            = 0;
      buf_cnt           = 0;
      hw_fetched        = 0;
      hw_taken          = 0;
      stalled           = 1'b0;
      timed_out         = 1'b0;
      hold_head         = 1'b0;
      after_flush       = 1'b0;
      last_i0           = '0;
      n                 = 0;
      while (arst_n !== 1'b1 && n < 10) begin
         @(posedge clk);
         n++;
      end
      if (arst_n !== 1'b1) begin
         $display("timeout: reset was never released");
         timed_out = 1'b1;
      end
      if (!timed_out)
         test_mixed();
      if (!timed_out)
         test_partial();
      if (!timed_out)
         test_faults();
      if (!timed_out)
         test_hold();
      if (!timed_out)
         test_flush();
      if (!timed_out)
         test_stall();
      $display("tests passed: %0d  failed: %0d  errors: %0d", n_pass, n_fail, errors);
      if (n_fail == 0 && errors == 0 && !timed_out)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// File: tb.f
src/aln_pkg.sv
src/fetch_buf_queue.sv
src/fetch_buf_ctl.sv
src/inst_aligner.sv
src/ifu_aln_ctl.sv
bench/clk_gen.sv
bench/tb_aln.sv

// File: run.sh
#!/bin/sh
# build and run the aligner testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_aln
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_aln)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
   exit 0
fi
exit 1
